// File: Makefile
SIM := obj_dir/Virq_ctrl_tb

.PHONY: all run clean

all: run

# Rebuilt only when a source, the header or the file list changes
$(SIM): list.f include/irq_consts.svh $(wildcard source/*.sv) $(wildcard bench/*.sv)
	verilator --binary --timing --assert -f list.f --top-module irq_ctrl_tb

# Log decides the result
run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then echo "run failed"; exit 1; fi
	@grep -q "SIMULATION PASSED" sim.log || (echo "run did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: bench/irq_ctrl_checker.sv
`timescale 1ns/100ps

`include "irq_consts.svh"

module irq_ctrl_checker
  import irq_pkg::*;
(
  input logic     clk_i,
  input logic     rst_ni,
  input irq_vec_t mie_i,
  input logic     mstatus_mie_i,
  input irq_vec_t mip_o,
  input logic     irq_ack_o,
  input irq_id_t  irq_id_o
);

  irq_vec_t id_onehot;

  // One-hot view of the acknowledged id
  assign id_onehot = irq_vec_t'(1) << irq_id_o;

  // ----------------------------------------
  // Acknowledge
  // ----------------------------------------

  // Pulse lasts exactly one cycle
  ack_one_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_ni) irq_ack_o |=> !irq_ack_o
  ) else $error("irq_ack_o held high for two cycles");

  // Id implemented, and enabled on the edge that decided the ack
  ack_id_enabled: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    irq_ack_o |-> |(id_onehot & `IRQ_VALID_MASK & $past(mie_i))
  ) else $error("irq_id_o %0d is not an enabled interrupt", irq_id_o);

  // Global enable low on the deciding edge means no ack
  ack_needs_mie: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !$past(mstatus_mie_i) |-> !irq_ack_o
  ) else $error("irq_ack_o raised while mstatus_mie_i was low");

  // ----------------------------------------
  // Pending register
  // ----------------------------------------

  mip_reserved_zero: assert property (
    @(posedge clk_i) disable iff (!rst_ni) (mip_o & ~`IRQ_VALID_MASK) == '0
  ) else $error("mip_o has a reserved bit set: %h", mip_o);

endmodule

bind irq_ctrl_top irq_ctrl_checker u_checker (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .mie_i         (mie_i),
  .mstatus_mie_i (mstatus_mie_i),
  .mip_o         (mip_o),
  .irq_ack_o     (irq_ack_o),
  .irq_id_o      (irq_id_o)
);

// File: bench/irq_ctrl_tb.sv
`timescale 1ns/100ps

`include "irq_consts.svh"

module irq_ctrl_tb
  import irq_pkg::*;
();

  logic        clk_i;
  logic        rst_ni;
  irq_vec_t    irq_i;
  irq_vec_t    mie_i;
  logic        mstatus_mie_i;
  logic        instr_valid_i;
  logic [31:0] instr_rdata_i;
  logic        instr_err_i;
  logic        lsu_busy_i;
  logic [1:0]  fetch_outstanding_i;
  logic        debug_req_i;
  irq_vec_t    mip_o;
  logic        irq_ack_o;
  irq_id_t     irq_id_o;
  logic        core_sleep_o;

  logic [31:0] lfsr_q;
  string       cur_test;
  int          n_tests = 0;
  int          n_failed = 0;
  int          n_checks = 0;
  int          n_errors = 0;
  int          test_base = 0;
  int          ack_count = 0;

  irq_ctrl_top DUT (.*);

  // 40 ns clock
  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // Random values and reference model
  // ----------------------------------------

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step for every bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Reserved lines are dropped
  function automatic irq_vec_t ref_mip(input irq_vec_t lines);
    return lines & `IRQ_VALID_MASK;
  endfunction

  // Lines 31 down to 16 first, then 11, 3, 7
  function automatic void ref_winner(input irq_vec_t pend, output logic valid,
                                     output irq_id_t id);
    irq_id_t low_ids[3] = '{5'd11, 5'd3, 5'd7};
    valid = 1'b0;
    id    = '0;
    for (int i = 31; i >= 16; i--) begin
      if (!valid && pend[irq_id_t'(i)]) begin
        valid = 1'b1;
        id    = irq_id_t'(i);
      end
    end
    foreach (low_ids[k]) begin
      if (!valid && pend[low_ids[k]]) begin
        valid = 1'b1;
        id    = low_ids[k];
      end
    end
  endfunction

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------

  task automatic tally(input bit ok, input string what, input string exp, input string act);
    n_checks++;
    if (!ok) begin
      n_errors++;
      $display("Mismatch %s %s: expected %s actual %s", cur_test, what, exp, act);
    end
  endtask

  task automatic check_vec(input string what, input irq_vec_t exp, input irq_vec_t act);
    tally(exp === act, what, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_id(input string what, input irq_id_t exp, input irq_id_t act);
    tally(exp === act, what, $sformatf("%0d", exp), $sformatf("%0d", act));
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    tally(exp === act, what, $sformatf("%b", exp), $sformatf("%b", act));
  endtask

  // Cycle counts and ack tallies
  task automatic check_int(input string what, input int exp, input int act);
    tally(exp == act, what, $sformatf("%0d", exp), $sformatf("%0d", act));
  endtask

  // ----------------------------------------
  // Sequencing
  // ----------------------------------------

  // Sample point and drive point, 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  // Edges until the chosen output reaches level, bounded by limit
  task automatic wait_level(input bit on_sleep, input logic level, input int limit,
                            input string what, output int edges, output bit seen);
    edges = 0;
    seen  = 1'b0;
    while (!seen && edges < limit) begin
      next_cycle();
      edges++;
      seen = ((on_sleep ? core_sleep_o : irq_ack_o) == level);
    end
    if (!seen) begin
      n_errors++;
      $display("Error in %s: %s did not happen within %0d cycles", cur_test, what, limit);
    end
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_base = n_errors;
  endtask

  task automatic end_test();
    n_tests++;
    if (n_errors == test_base) begin
      $display("Test %s: ok", cur_test);
    end else begin
      n_failed++;
      $display("Test %s: %0d errors", cur_test, n_errors - test_base);
    end
  endtask

  // Retire a WFI, hold the LSU busy, then a fetch in flight, then drain
  task automatic enter_sleep(input int busy, output int edges, output bit seen);
    instr_valid_i = 1'b1;
    instr_rdata_i = `WFI_INSTR;
    lsu_busy_i    = 1'b1;
    next_cycle();
    instr_valid_i = 1'b0;
    instr_rdata_i = '0;
    repeat (busy) begin
      next_cycle();
      check_bit("sleep while lsu busy", 1'b0, core_sleep_o);
    end
    lsu_busy_i          = 1'b0;
    fetch_outstanding_i = 2'd2;
    repeat (busy) begin
      next_cycle();
      check_bit("sleep while fetch outstanding", 1'b0, core_sleep_o);
    end
    fetch_outstanding_i = 2'd0;
    wait_level(1'b1, 1'b1, 8, "sleep entry", edges, seen);
  endtask

  // mip checked one cycle behind irq_i, acks counted
  always @(posedge clk_i) begin
    irq_vec_t irq_seen;
    logic     rst_seen;
    irq_seen = irq_i;
    rst_seen = rst_ni;
    #1;
    if (rst_seen && rst_ni) begin
      check_vec("mip", ref_mip(irq_seen), mip_o);
    end
    if (irq_ack_o) begin
      ack_count++;
    end
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------

  initial begin
    int       edges;
    int       busy;
    int       acks;
    bit       seen;
    logic     win_v;
    irq_id_t  win_id;
    irq_id_t  b;
    irq_vec_t lines;
    irq_vec_t en;

    lfsr_q              = 32'hd1f1736d;
    rst_ni              = 1'b0;
    irq_i               = '0;
    mie_i               = '0;
    mstatus_mie_i       = 1'b0;
    instr_valid_i       = 1'b0;
    instr_rdata_i       = '0;
    instr_err_i         = 1'b0;
    lsu_busy_i          = 1'b0;
    fetch_outstanding_i = 2'd0;
    debug_req_i         = 1'b0;

    // Reset for 10 cycles
    start_test("reset");
    repeat (10) next_cycle();
    check_vec("mip", '0, mip_o);
    check_bit("ack", 1'b0, irq_ack_o);
    check_bit("sleep", 1'b0, core_sleep_o);
    rst_ni = 1'b1;
    end_test();

    // Random lines with mie clear, mip checked by the monitor
    start_test("mip_follow");
    mstatus_mie_i = 1'b1;
    acks = ack_count;
    repeat (16) begin
      irq_i = rand_bits(32);
      next_cycle();
    end
    irq_i = '0;
    repeat (2) next_cycle();
    check_int("ack count", acks, ack_count);
    end_test();

    // Each winner acked two edges after its set, then cleared
    start_test("arbitration");
    repeat (8) begin
      b     = irq_id_t'(16 + rand_bits(4));
      lines = rand_bits(32);
      en    = rand_bits(32);
      lines[b] = 1'b1;
      en[b]    = 1'b1;
      irq_i = lines;
      mie_i = en;
      ref_winner(ref_mip(lines) & en, win_v, win_id);
      while (win_v) begin
        wait_level(1'b0, 1'b1, 6, "acknowledge", edges, seen);
        if (seen) begin
          check_int("ack delay", 2, edges);
          check_id("ack id", win_id, irq_id_o);
        end
        lines[win_id] = 1'b0;
        irq_i = lines;
        ref_winner(ref_mip(lines) & en, win_v, win_id);
      end
      irq_i = '0;
      mie_i = '0;
      repeat (3) next_cycle();
    end
    end_test();

    // Pending and enabled, held off by mstatus.mie
    start_test("global_mask");
    mstatus_mie_i = 1'b0;
    b     = irq_id_t'(16 + rand_bits(4));
    lines = rand_bits(32);
    en    = rand_bits(32);
    lines[b] = 1'b1;
    en[b]    = 1'b1;
    irq_i = lines;
    mie_i = en;
    acks  = ack_count;
    repeat (8) next_cycle();
    check_int("ack count", acks, ack_count);
    ref_winner(ref_mip(lines) & en, win_v, win_id);
    mstatus_mie_i = 1'b1;
    wait_level(1'b0, 1'b1, 4, "acknowledge", edges, seen);
    if (seen) begin
      check_id("ack id", win_id, irq_id_o);
    end
    irq_i         = '0;
    mie_i         = '0;
    mstatus_mie_i = 1'b0;
    repeat (3) next_cycle();
    end_test();

    // Faulted WFI first, then a real one behind back-pressure
    start_test("sleep_entry");
    instr_valid_i = 1'b1;
    instr_rdata_i = `WFI_INSTR;
    instr_err_i   = 1'b1;
    next_cycle();
    instr_valid_i = 1'b0;
    instr_rdata_i = '0;
    instr_err_i   = 1'b0;
    repeat (`SLEEP_LATENCY + 4) begin
      next_cycle();
      check_bit("sleep after faulted wfi", 1'b0, core_sleep_o);
    end
    busy = 1 + int'(rand_bits(3));
    enter_sleep(busy, edges, seen);
    // First ready edge, then the latency
    if (seen) begin
      check_int("sleep delay", `SLEEP_LATENCY + 1, edges);
    end
    end_test();

    // Wake by an enabled line without ack, then by debug alone
    start_test("wakeup");
    b    = irq_id_t'(16 + rand_bits(4));
    acks = ack_count;
    irq_i[b] = 1'b1;
    mie_i[b] = 1'b1;
    wait_level(1'b1, 1'b0, 6, "irq wake", edges, seen);
    if (seen) begin
      check_int("irq wake delay", 2, edges);
    end
    repeat (3) next_cycle();
    check_int("ack count", acks, ack_count);
    irq_i = '0;
    mie_i = '0;
    repeat (3) next_cycle();
    enter_sleep(1, edges, seen);
    debug_req_i = 1'b1;
    wait_level(1'b1, 1'b0, 4, "debug wake", edges, seen);
    if (seen) begin
      check_int("debug wake delay", 1, edges);
    end
    debug_req_i = 1'b0;
    repeat (2) next_cycle();
    end_test();

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             n_tests, n_failed, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: include/irq_consts.svh
`ifndef IRQ_CONSTS_SVH
`define IRQ_CONSTS_SVH

// ----------------------------------------
// Interrupt line set
// ----------------------------------------

// Number of machine interrupt lines
`define IRQ_NUM 32

// Width of an interrupt number
`define IRQ_ID_W 5

// Implemented lines 31..16, 11, 7 and 3
`define IRQ_VALID_MASK 32'hffff_0888

// ----------------------------------------
// Sleep control
// ----------------------------------------

// Encoding of the WFI instruction word
`define WFI_INSTR 32'h1050_0073

// Cycles from a drained pipeline to core sleep
`define SLEEP_LATENCY 2

`endif

// File: list.f
+incdir+include
source/irq_pkg.sv
source/irq_pending_reg.sv
source/irq_priority_arb.sv
source/wfi_sleep_fsm.sv
source/sleep_delay_timer.sv
source/irq_ctrl_top.sv
bench/irq_ctrl_checker.sv
bench/irq_ctrl_tb.sv

// File: source/irq_ctrl_top.sv
`timescale 1ns/100ps

module irq_ctrl_top
  import irq_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,

  // Interrupt lines and CSR enables
  input  irq_vec_t    irq_i,
  input  irq_vec_t    mie_i,
  input  logic        mstatus_mie_i,

  // Retiring instruction
  input  logic        instr_valid_i,
  input  logic [31:0] instr_rdata_i,
  input  logic        instr_err_i,

  // Pipeline status and debug
  input  logic        lsu_busy_i,
  input  logic [1:0]  fetch_outstanding_i,
  input  logic        debug_req_i,

  // Outputs
  output irq_vec_t    mip_o,
  output logic        irq_ack_o,
  output irq_id_t     irq_id_o,
  output logic        core_sleep_o
);

  // ----------------------------------------
  // Internal nets
  // ----------------------------------------

  irq_vec_t pending_en;
  logic     timer_start;
  logic     timer_clear;
  logic     timer_done;

  // mip register and enabled view
  irq_pending_reg u_pending (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .irq_i        (irq_i),
    .mie_i        (mie_i),
    .mip_o        (mip_o),
    .pending_en_o (pending_en)
  );

  // Fixed-order arbiter and ack pulse
  irq_priority_arb u_arb (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .pending_en_i  (pending_en),
    .mstatus_mie_i (mstatus_mie_i),
    .irq_ack_o     (irq_ack_o),
    .irq_id_o      (irq_id_o)
  );

  // WFI sequencing
  wfi_sleep_fsm u_wfi (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .instr_valid_i       (instr_valid_i),
    .instr_rdata_i       (instr_rdata_i),
    .instr_err_i         (instr_err_i),
    .lsu_busy_i          (lsu_busy_i),
    .fetch_outstanding_i (fetch_outstanding_i),
    .debug_req_i         (debug_req_i),
    .pending_en_i        (pending_en),
    .timer_done_i        (timer_done),
    .timer_start_o       (timer_start),
    .timer_clear_o       (timer_clear),
    .core_sleep_o        (core_sleep_o)
  );

  // Sleep-entry latency
  sleep_delay_timer u_timer (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (timer_start),
    .clear_i (timer_clear),
    .done_o  (timer_done)
  );

endmodule

// File: source/irq_pending_reg.sv
`timescale 1ns/100ps

`include "irq_consts.svh"

module irq_pending_reg
  import irq_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,

  // Raw interrupt lines and local enables
  input  irq_vec_t irq_i,
  input  irq_vec_t mie_i,

  // Pending register and its enabled view
  output irq_vec_t mip_o,
  output irq_vec_t pending_en_o
);

  // ----------------------------------------
  // Pending register
  // ----------------------------------------

  irq_vec_t mip_q;
  irq_vec_t irq_masked;

  // Reserved lines never reach mip
  assign irq_masked = irq_i & `IRQ_VALID_MASK;

  // One cycle from irq_i to mip
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_masked;
    end
  end

  assign mip_o = mip_q;

  // ----------------------------------------
  // Pending and enabled
  // ----------------------------------------

  // Shared by the arbiter and the WFI wake logic
  assign pending_en_o = mip_q & mie_i;

endmodule

// File: source/irq_pkg.sv
`include "irq_consts.svh"

package irq_pkg;

  // ----------------------------------------
  // Interrupt types
  // ----------------------------------------

  // One bit per interrupt line, same layout as mip/mie
  typedef logic [`IRQ_NUM-1:0] irq_vec_t;

  // Interrupt number as reported with the acknowledge
  typedef logic [`IRQ_ID_W-1:0] irq_id_t;

  // ----------------------------------------
  // WFI sleep FSM
  // ----------------------------------------

  // RUN   normal execution
  // DRAIN WFI retired, waiting for LSU and fetch to go idle
  // WAIT  pipeline idle, sleep latency timer running
  // SLEEP core_sleep_o asserted
  typedef enum logic [1:0] {
    WFI_RUN   = 2'b00,
    WFI_DRAIN = 2'b01,
    WFI_WAIT  = 2'b10,
    WFI_SLEEP = 2'b11
  } wfi_state_e;

endpackage

// File: source/irq_priority_arb.sv
`timescale 1ns/100ps

`include "irq_consts.svh"

module irq_priority_arb
  import irq_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,

  // Pending and locally enabled lines
  input  irq_vec_t pending_en_i,

  // Global machine interrupt enable
  input  logic     mstatus_mie_i,

  // Acknowledge pulse and winning id
  output logic     irq_ack_o,
  output irq_id_t  irq_id_o
);

  // ----------------------------------------
  // Winner selection
  // ----------------------------------------

  logic    win_valid;
  irq_id_t win_id;

  // Lowest priority is checked first so later hits override it
  // Resulting order is 31..16, then 11, then 3, then 7
  always_comb begin
    win_valid = 1'b0;
    win_id    = '0;

    // Line 7 is the weakest
    if (pending_en_i[7]) begin
      win_valid = 1'b1;
      win_id    = irq_id_t'(7);
    end

    // Line 3 beats 7
    if (pending_en_i[3]) begin
      win_valid = 1'b1;
      win_id    = irq_id_t'(3);
    end

    // Line 11 beats 3 and 7
    if (pending_en_i[11]) begin
      win_valid = 1'b1;
      win_id    = irq_id_t'(11);
    end

    // Platform lines, higher index wins
    for (int i = 16; i < `IRQ_NUM; i++) begin
      if (pending_en_i[i]) begin
        win_valid = 1'b1;
        win_id    = irq_id_t'(i);
      end
    end
  end

  // ----------------------------------------
  // Acknowledge register
  // ----------------------------------------

  logic    ack_q;
  irq_id_t id_q;

  // Ack only under mstatus.mie; a high ack forces a low cycle after it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= win_valid & mstatus_mie_i & ~ack_q;
    end
  end

  // Id tracks the winner, only meaningful with ack
  always_ff @(posedge clk_i) begin
    if (win_valid) begin
      id_q <= win_id;
    end
  end

  assign irq_ack_o = ack_q;
  assign irq_id_o  = id_q;

endmodule

// File: source/sleep_delay_timer.sv
`timescale 1ns/100ps

`include "irq_consts.svh"

module sleep_delay_timer (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic start_i,
  input  logic clear_i,
  output logic done_o
);

  // ----------------------------------------
  // Latency down-counter
  // ----------------------------------------

  localparam int unsigned CNT_W = $clog2(`SLEEP_LATENCY + 1);

  logic [CNT_W-1:0] cnt_q;

  // Zero means idle; load wins over clear, count stops at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= CNT_W'(`SLEEP_LATENCY);
    end else if (clear_i) begin
      cnt_q <= '0;
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Final count reached SLEEP_LATENCY-1 edges after the load
  assign done_o = (cnt_q == CNT_W'(1));

endmodule

// File: source/wfi_sleep_fsm.sv
`timescale 1ns/100ps

`include "irq_consts.svh"

module wfi_sleep_fsm
  import irq_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,

  // Writeback stage view of the retiring instruction
  input  logic        instr_valid_i,
  input  logic [31:0] instr_rdata_i,
  input  logic        instr_err_i,

  // Pipeline activity
  input  logic        lsu_busy_i,
  input  logic [1:0]  fetch_outstanding_i,

  // Wake sources
  input  logic        debug_req_i,
  input  irq_vec_t    pending_en_i,

  // Sleep latency timer
  input  logic        timer_done_i,
  output logic        timer_start_o,
  output logic        timer_clear_o,

  output logic        core_sleep_o
);

  // ----------------------------------------
  // Decode and conditions
  // ----------------------------------------

  logic       wfi_retired;
  logic       pipe_ready;
  logic       wake;
  wfi_state_e state_q;
  wfi_state_e state_d;
  logic       sleep_q;

  // WFI with a bus error does not count as retired
  assign wfi_retired = instr_valid_i && (instr_rdata_i == `WFI_INSTR) && !instr_err_i;

  // No LSU transfer and no fetch in flight
  assign pipe_ready = !lsu_busy_i && (fetch_outstanding_i == 2'd0);

  // Wake ignores mstatus.mie
  assign wake = (|pending_en_i) || debug_req_i;

  // ----------------------------------------
  // Next state
  // ----------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      WFI_RUN: begin
        if (wfi_retired) state_d = WFI_DRAIN;
      end
      WFI_DRAIN: begin
        if (wake) state_d = WFI_RUN;
        else if (pipe_ready) state_d = WFI_WAIT;
      end
      WFI_WAIT: begin
        if (wake) state_d = WFI_RUN;
        else if (timer_done_i) state_d = WFI_SLEEP;
      end
      WFI_SLEEP: begin
        if (wake) state_d = WFI_RUN;
      end
      default: state_d = WFI_RUN;
    endcase
  end

  // Timer load on the drain-to-wait edge
  assign timer_start_o = (state_q == WFI_DRAIN) && pipe_ready && !wake;

  // Any wake outside RUN abandons a running count
  assign timer_clear_o = (state_q != WFI_RUN) && wake;

  // ----------------------------------------
  // State and sleep registers
  // ----------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= WFI_RUN;
      sleep_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Rises on the edge that samples timer_done, falls on wake
      sleep_q <= (state_d == WFI_SLEEP);
    end
  end

  assign core_sleep_o = sleep_q;

endmodule
